//--- Bender.yml
package:
  name: conv_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/conv_pkg.sv
      - hw/feature_ram.sv
      - hw/stream_loader.sv
      - conv_engine/window_scan.sv
      - conv_engine/mac3x3.sv
      - conv_engine/requant_pack.sv
      - hw/conv_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/conv_assert.sv
      - testbench/tb_conv.sv

//--- common/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// stream word layout
`define CONV_DATA_W      32
`define CONV_PIX_W       8
`define CONV_LANES       4

// feature map storage
`define CONV_MAX_WIDTH   32
`define CONV_FEAT_DEPTH  256   // 32x32 pixels at four per word

// arithmetic
`define CONV_ACC_W       32
`define CONV_FRAC_BITS   6     // bias is pre-scaled by this and results shifted back
`define CONV_TAPS        9

// coefficient load is three weight words plus one bias word
`define CONV_COEF_WORDS  4

`endif

//--- common/conv_pkg.sv
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

  typedef enum logic [2:0] {
    CMD_IDLE         = 3'd0,
    CMD_LOAD_FEATURE = 3'd1,
    CMD_LOAD_COEF    = 3'd2,
    CMD_RUN          = 3'd3
  } cmd_e;

  typedef logic [5:0] dim_t;  // map side up to 32

  typedef logic signed [`CONV_PIX_W-1:0] pix_t;

  // one stream word read as pixel lanes or as the bias word
  typedef union packed {
    pix_t [`CONV_LANES-1:0]          lane;  // lane 0 in the low byte
    logic signed [`CONV_DATA_W-1:0]  bias;
  } stream_word_u;

  typedef struct packed {
    stream_word_u data;
    logic         last;
  } axis_beat_t;

  typedef struct packed {
    pix_t [`CONV_TAPS-1:0]           tap;   // row-major kernel
    logic signed [`CONV_DATA_W-1:0]  bias;
  } coef_t;

  typedef struct packed {
    pix_t [`CONV_TAPS-1:0] feat;  // row-major with index 0 at top left
  } window_t;

  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

//--- conv_engine/mac3x3.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module mac3x3 (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              stall,
  input  wire logic              win_valid,
  input  wire conv_pkg::window_t win,
  input  wire conv_pkg::coef_t   coef,
  output logic                   acc_valid,
  output conv_pkg::acc_t         acc
);
  import conv_pkg::*;

  localparam int PROD_W = 2 * `CONV_PIX_W;

  logic signed [PROD_W-1:0] prod [`CONV_TAPS];
  logic                     prod_valid;
  acc_t                     sum;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      prod_valid <= 1'b0;
      acc_valid  <= 1'b0;
    end else if (!stall) begin
      prod_valid <= win_valid;
      acc_valid  <= prod_valid;
    end
  end

  // stage one forms the nine signed products
  always_ff @(posedge clk) begin
    if (win_valid && !stall) begin
      for (int i = 0; i < `CONV_TAPS; i++) begin
        prod[i] <= $signed(win.feat[i]) * $signed(coef.tap[i]);
      end
    end
  end

  // stage two adds the products to the scaled bias
  always_comb begin
    sum = acc_t'(coef.bias) <<< `CONV_FRAC_BITS;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      sum = sum + acc_t'(prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid && !stall) begin
      acc <= sum;
    end
  end

endmodule

`default_nettype wire

//--- conv_engine/requant_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module requant_pack (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire conv_pkg::cmd_e    state,
  input  wire conv_pkg::dim_t    width_cfg,
  input  wire logic              acc_valid,
  input  wire conv_pkg::acc_t    acc,
  output logic                   m_valid,
  output conv_pkg::axis_beat_t   m_beat,
  input  wire logic              m_ready,
  output logic                   stall,
  output logic                   conv_done
);
  import conv_pkg::*;

  localparam int SAT_MAX = 2 ** (`CONV_PIX_W - 1) - 1;
  localparam int LW      = $clog2(`CONV_LANES);

  acc_t          shifted;
  pix_t          res;
  stream_word_u  pack;
  logic [LW-1:0] lane_cnt;
  logic [9:0]    word_cnt;
  logic [11:0]   map_px;
  logic [9:0]    words_total;
  logic          take;
  logic          full;

  assign stall = m_valid && !m_ready;
  assign take  = acc_valid && !stall;
  assign full  = take && (lane_cnt == LW'(`CONV_LANES - 1));

  assign map_px      = {6'd0, width_cfg} * {6'd0, width_cfg};
  assign words_total = map_px[11:2];

  // relu, then drop the fraction and clip
  assign shifted = acc >>> `CONV_FRAC_BITS;
  always_comb begin
    if (acc < 0) begin
      res = '0;
    end else if (shifted > acc_t'(SAT_MAX)) begin
      res = pix_t'(SAT_MAX);
    end else begin
      res = pix_t'(shifted);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m_valid   <= 1'b0;
      lane_cnt  <= '0;
      word_cnt  <= '0;
      conv_done <= 1'b0;
    end else if (state == CMD_IDLE) begin
      m_valid   <= 1'b0;
      lane_cnt  <= '0;
      word_cnt  <= '0;
      conv_done <= 1'b0;
    end else begin
      if (full) begin
        m_valid <= 1'b1;  // output register is free whenever we are not stalled
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
      if (take) begin
        lane_cnt <= lane_cnt + 1'b1;
      end
      if (full) begin
        word_cnt <= word_cnt + 10'd1;
      end
      if (m_valid && m_ready && m_beat.last) begin
        conv_done <= 1'b1;
      end
    end
  end

  // results enter at the top lane, so the first one ends in lane 0
  always_ff @(posedge clk) begin
    if (take) begin
      pack.lane <= {res, pack.lane[`CONV_LANES-1:1]};
    end
    if (full) begin
      m_beat.data.lane <= {res, pack.lane[`CONV_LANES-1:1]};
      m_beat.last      <= (word_cnt == words_total - 10'd1);
    end
  end

endmodule

`default_nettype wire

//--- conv_engine/window_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module window_scan (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  input  wire conv_pkg::cmd_e         state,
  input  wire conv_pkg::dim_t         width_cfg,
  input  wire logic                   stall,
  output logic                        rd_en,
  output logic [7:0]                  rd_addr,
  input  wire conv_pkg::stream_word_u rd_data,
  output logic                        win_valid,
  output conv_pkg::window_t           win
);
  import conv_pkg::*;

  localparam int IW = $clog2(`CONV_MAX_WIDTH);  // bits of a pixel index

  dim_t       row;
  dim_t       col;
  logic [1:0] tap_r;
  logic [1:0] tap_c;
  logic       issue_done;
  logic       active;
  logic       step;
  dim_t       r_p1;
  dim_t       c_p1;
  dim_t       r_m;
  dim_t       c_m;
  logic       in_map;
  logic [3:0] wpr;
  logic [8:0] addr_full;
  logic [3:0] tap_idx;
  logic       p_valid;
  logic       p_inmap;
  logic [3:0] p_tap;
  logic [1:0] p_lane;

  assign active = (state == CMD_RUN) && !issue_done;
  assign step   = active && !stall;

  // source coordinates kept off by one so the top and left pad stay unsigned
  assign r_p1   = row + dim_t'(tap_r);
  assign c_p1   = col + dim_t'(tap_c);
  assign in_map = (r_p1 != '0) && (r_p1 <= width_cfg) &&
                  (c_p1 != '0) && (c_p1 <= width_cfg);
  assign r_m    = r_p1 - 6'd1;
  assign c_m    = c_p1 - 6'd1;

  assign wpr       = width_cfg[5:2];  // words per map row
  assign addr_full = 9'(r_m[IW-1:0]) * 9'(wpr) + 9'(c_m[IW-1:2]);
  assign tap_idx   = 4'(tap_r) * 4'd3 + 4'(tap_c);

  assign rd_en   = step && in_map;  // pad taps read nothing
  assign rd_addr = addr_full[7:0];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row        <= '0;
      col        <= '0;
      tap_r      <= '0;
      tap_c      <= '0;
      issue_done <= 1'b0;
      p_valid    <= 1'b0;
      win_valid  <= 1'b0;
    end else if (state == CMD_IDLE) begin
      row        <= '0;
      col        <= '0;
      tap_r      <= '0;
      tap_c      <= '0;
      issue_done <= 1'b0;
      p_valid    <= 1'b0;
      win_valid  <= 1'b0;
    end else begin
      if (step) begin
        if (tap_c != 2'd2) begin
          tap_c <= tap_c + 2'd1;
        end else begin
          tap_c <= '0;
          if (tap_r != 2'd2) begin
            tap_r <= tap_r + 2'd1;
          end else begin
            tap_r <= '0;
            if (col != width_cfg - 6'd1) begin
              col <= col + 6'd1;
            end else begin
              col <= '0;
              if (row != width_cfg - 6'd1) begin
                row <= row + 6'd1;
              end else begin
                issue_done <= 1'b1;  // all windows issued
              end
            end
          end
        end
      end
      if (!stall) begin
        p_valid   <= step;
        win_valid <= p_valid && (p_tap == 4'(`CONV_TAPS - 1));
      end
    end
  end

  // tap bookkeeping follows the ram by one cycle
  always_ff @(posedge clk) begin
    if (step) begin
      p_tap   <= tap_idx;
      p_lane  <= c_m[1:0];
      p_inmap <= in_map;
    end
    if (p_valid && !stall) begin
      win.feat[p_tap] <= p_inmap ? rd_data.lane[p_lane] : '0;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/conv_pkg.sv
hw/feature_ram.sv
hw/stream_loader.sv
conv_engine/window_scan.sv
conv_engine/mac3x3.sv
conv_engine/requant_pack.sv
hw/conv_top.sv
testbench/conv_assert.sv
testbench/tb_conv.sv

//--- hw/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_top (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire conv_pkg::cmd_e       command,
  input  wire conv_pkg::dim_t       width_cfg,
  input  wire logic                 s_valid,
  input  wire conv_pkg::axis_beat_t s_beat,
  output logic                      s_ready,
  output logic                      m_valid,
  output conv_pkg::axis_beat_t      m_beat,
  input  wire logic                 m_ready,
  output logic                      feature_done,
  output logic                      coef_done,
  output logic                      conv_done
);
  import conv_pkg::*;

  cmd_e         state;
  dim_t         width_q;
  logic         wr_en;
  logic [7:0]   wr_addr;
  stream_word_u wr_data;
  coef_t        coef;
  logic         rd_en;
  logic [7:0]   rd_addr;
  stream_word_u rd_data;
  logic         win_valid;
  window_t      win;
  logic         acc_valid;
  acc_t         acc;
  logic         stall;

  // host levels take effect one cycle later
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= CMD_IDLE;
      width_q <= '0;
    end else begin
      state   <= command;
      width_q <= width_cfg;
    end
  end

  stream_loader u_loader (
    .clk          (clk),
    .rstn         (rstn),
    .state        (state),
    .s_valid      (s_valid),
    .s_beat       (s_beat),
    .s_ready      (s_ready),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .coef         (coef),
    .feature_done (feature_done),
    .coef_done    (coef_done)
  );

  feature_ram #(
    .DEPTH (`CONV_FEAT_DEPTH)
  ) u_feature_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  window_scan u_scan (
    .clk       (clk),
    .rstn      (rstn),
    .state     (state),
    .width_cfg (width_q),
    .stall     (stall),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .win_valid (win_valid),
    .win       (win)
  );

  mac3x3 u_mac (
    .clk       (clk),
    .rstn      (rstn),
    .stall     (stall),
    .win_valid (win_valid),
    .win       (win),
    .coef      (coef),
    .acc_valid (acc_valid),
    .acc       (acc)
  );

  requant_pack u_requant (
    .clk       (clk),
    .rstn      (rstn),
    .state     (state),
    .width_cfg (width_q),
    .acc_valid (acc_valid),
    .acc       (acc),
    .m_valid   (m_valid),
    .m_beat    (m_beat),
    .m_ready   (m_ready),
    .stall     (stall),
    .conv_done (conv_done)
  );

endmodule

`default_nettype wire

//--- hw/feature_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module feature_ram #(
  parameter int DEPTH = `CONV_FEAT_DEPTH
) (
  input  wire logic                   clk,
  input  wire logic                   wr_en,
  input  wire logic [7:0]             wr_addr,
  input  wire conv_pkg::stream_word_u wr_data,
  input  wire logic                   rd_en,
  input  wire logic [7:0]             rd_addr,
  output conv_pkg::stream_word_u      rd_data
);
  import conv_pkg::*;

  stream_word_u mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // one cycle read latency and holds when idle
    end
  end

endmodule

`default_nettype wire

//--- hw/stream_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module stream_loader (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire conv_pkg::cmd_e       state,
  input  wire logic                 s_valid,
  input  wire conv_pkg::axis_beat_t s_beat,
  output logic                      s_ready,
  output logic                      wr_en,
  output logic [7:0]                wr_addr,
  output conv_pkg::stream_word_u    wr_data,
  output conv_pkg::coef_t           coef,
  output logic                      feature_done,
  output logic                      coef_done
);
  import conv_pkg::*;

  logic [7:0] beat_cnt;
  logic       accept;
  logic       feat_beat;
  logic       coef_beat;

  assign s_ready = (state == CMD_LOAD_FEATURE && !feature_done) ||
                   (state == CMD_LOAD_COEF && !coef_done);
  assign accept    = s_valid && s_ready;
  assign feat_beat = accept && (state == CMD_LOAD_FEATURE);
  assign coef_beat = accept && (state == CMD_LOAD_COEF);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt     <= '0;
      wr_en        <= 1'b0;
      feature_done <= 1'b0;
      coef_done    <= 1'b0;
    end else if (state == CMD_IDLE) begin
      beat_cnt     <= '0;
      wr_en        <= 1'b0;
      feature_done <= 1'b0;
      coef_done    <= 1'b0;
    end else begin
      wr_en <= feat_beat;  // ram write lands one edge after the beat
      if (accept) begin
        beat_cnt <= s_beat.last ? 8'd0 : beat_cnt + 8'd1;
      end
      if (feat_beat && s_beat.last) begin
        feature_done <= 1'b1;
      end
      if (coef_beat && s_beat.last) begin
        coef_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (feat_beat) begin
      wr_addr <= beat_cnt;
      wr_data <= s_beat.data;
    end
  end

  // coefficients survive idle so a new run can reuse them
  always_ff @(posedge clk) begin
    if (coef_beat && (beat_cnt < 8'(`CONV_COEF_WORDS))) begin
      case (beat_cnt[1:0])
        2'd0:    coef.tap[3:0] <= s_beat.data.lane;
        2'd1:    coef.tap[7:4] <= s_beat.data.lane;
        2'd2:    coef.tap[8]   <= s_beat.data.lane[0];  // lanes 1..3 unused
        default: coef.bias     <= s_beat.data.bias;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- testbench/conv_assert.sv
`timescale 1ns/1ps
`default_nettype none

module conv_assert (
  input wire logic                 clk,
  input wire logic                 rstn,
  input wire conv_pkg::cmd_e       state,
  input wire logic                 s_ready,
  input wire logic                 m_valid,
  input wire conv_pkg::axis_beat_t m_beat,
  input wire logic                 m_ready,
  input wire logic                 feature_done,
  input wire logic                 coef_done,
  input wire logic                 conv_done
);
  import conv_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench at the end

  // a stalled master beat holds until taken
  beat_held: assert property (@(posedge clk) disable iff (!rstn)
    (m_valid && !m_ready) |=> $stable(m_beat))
    else begin
      fail_count++;
      $error("m_beat changed while m_valid was high and m_ready low");
    end

  ready_only_in_load: assert property (@(posedge clk) disable iff (!rstn)
    !(state inside {CMD_LOAD_FEATURE, CMD_LOAD_COEF}) |-> !s_ready)
    else begin
      fail_count++;
      $error("s_ready high outside the load states");
    end

  flags_clear_in_idle: assert property (@(posedge clk) disable iff (!rstn)
    (state == CMD_IDLE) |=> (!feature_done && !coef_done && !conv_done))
    else begin
      fail_count++;
      $error("a done flag stayed high one cycle after idle");
    end

endmodule

bind conv_top conv_assert u_assert (
  .clk          (clk),
  .rstn         (rstn),
  .state        (state),
  .s_ready      (s_ready),
  .m_valid      (m_valid),
  .m_beat       (m_beat),
  .m_ready      (m_ready),
  .feature_done (feature_done),
  .coef_done    (coef_done),
  .conv_done    (conv_done)
);

`default_nettype wire

//--- testbench/tb_conv.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_conv;
  import conv_pkg::*;

  localparam int NROWS     = 5;
  localparam int WAIT_MAX  = 2000;  // cycles allowed for any single wait
  localparam int F_FEATURE = 0;
  localparam int F_COEF    = 1;
  localparam int F_CONV    = 2;

  logic       clk = 1'b0;
  logic       rstn;
  cmd_e       command;
  dim_t       width_cfg;
  logic       s_valid;
  axis_beat_t s_beat;
  logic       s_ready;
  logic       m_valid;
  axis_beat_t m_beat;
  logic       m_ready;
  logic       feature_done;
  logic       coef_done;
  logic       conv_done;

  // one row per run, the last one keeps the coefficients of the row before
  string row_name   [NROWS] = '{"pad_w4", "sat_w8", "relu_w8", "full_w32", "reuse_w12"};
  int    row_width  [NROWS] = '{4, 8, 8, 32, 12};
  int    row_kernel [NROWS][9] = '{
    '{1, 2, 1, 2, 4, 2, 1, 2, 1},
    '{3, -1, 2, 0, 5, -4, 1, 1, -2},
    '{3, -1, 2, 0, 5, -4, 1, 1, -2},
    '{-2, 7, 1, 4, -3, 6, 0, 2, 5},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0}
  };
  int    row_bias   [NROWS] = '{0, 5000, -5000, 40, 0};
  bit    row_rand   [NROWS] = '{0, 0, 1, 0, 1};    // random m_ready
  bit    row_load   [NROWS] = '{1, 1, 1, 1, 0};    // load coefficients first
  int    row_const  [NROWS] = '{-1, 127, 0, -1, -1};  // value of every output pixel or -1 if mixed

  logic [31:0] seed = 32'h2dfc38e0;
  int          feat [1024];       // current map in raster order
  int          cur_kernel [9];
  int          cur_bias;
  logic [31:0] tx_words [$];

  conv_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .command      (command),
    .width_cfg    (width_cfg),
    .s_valid      (s_valid),
    .s_beat       (s_beat),
    .s_ready      (s_ready),
    .m_valid      (m_valid),
    .m_beat       (m_beat),
    .m_ready      (m_ready),
    .feature_done (feature_done),
    .coef_done    (coef_done),
    .conv_done    (conv_done)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %08h, actual %08h", what, expected, actual);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("Test failures found");
    $fatal(1, "wait timed out");
  endtask

  function automatic logic flag_value(input int which);
    case (which)
      F_FEATURE: return feature_done;
      F_COEF:    return coef_done;
      default:   return conv_done;
    endcase
  endfunction

  task automatic wait_flag(input string what, input int which, input logic level);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (flag_value(which) !== level) begin
      if (cnt == WAIT_MAX) begin
        report_timeout(what);
      end
      cnt++;
      @(negedge clk);
    end
  endtask

  // sends tx_words in order with last on the final beat
  task automatic push_stream(input string what);
    int i;
    int cnt;
    i = 0;
    cnt = 0;
    @(posedge clk);
    s_valid          <= 1'b1;
    s_beat.data.bias <= tx_words[0];
    s_beat.last      <= (tx_words.size() == 1);
    while (i < tx_words.size()) begin
      @(negedge clk);
      if (s_ready) begin
        i++;  // transfers on the coming edge
        cnt = 0;
      end else if (cnt == WAIT_MAX) begin
        report_timeout(what);
      end else begin
        cnt++;
      end
      @(posedge clk);
      if (i < tx_words.size()) begin
        s_beat.data.bias <= tx_words[i];
        s_beat.last      <= (i == tx_words.size() - 1);
      end else begin
        s_valid <= 1'b0;
      end
    end
  endtask

  task automatic return_to_idle();
    @(posedge clk);
    command <= CMD_IDLE;
    m_ready <= 1'b1;
    wait_flag("feature_done to clear in idle", F_FEATURE, 1'b0);
    wait_flag("coef_done to clear in idle", F_COEF, 1'b0);
    wait_flag("conv_done to clear in idle", F_CONV, 1'b0);
  endtask

  task automatic load_feature(input int t);
    int          w;
    logic [31:0] rnd;
    w = row_width[t];
    for (int p = 0; p < w * w; p++) begin
      rnd = lcg_next();
      feat[p] = int'($signed(rnd[23:16]));
    end
    tx_words.delete();
    for (int k = 0; k < w * w / 4; k++) begin
      tx_words.push_back({8'(feat[4*k+3]), 8'(feat[4*k+2]), 8'(feat[4*k+1]), 8'(feat[4*k])});
    end
    @(posedge clk);
    command   <= CMD_LOAD_FEATURE;
    width_cfg <= dim_t'(w);
    push_stream("a feature beat to be accepted");
    wait_flag("feature_done", F_FEATURE, 1'b1);
    check($sformatf("%s s_ready after feature load", row_name[t]), 32'd0, 32'(s_ready));
  endtask

  task automatic load_coef(input int t);
    logic [31:0] rnd;
    for (int i = 0; i < 9; i++) begin
      cur_kernel[i] = row_kernel[t][i];
    end
    cur_bias = row_bias[t];
    rnd = lcg_next();
    tx_words.delete();
    tx_words.push_back({8'(cur_kernel[3]), 8'(cur_kernel[2]), 8'(cur_kernel[1]),
                        8'(cur_kernel[0])});
    tx_words.push_back({8'(cur_kernel[7]), 8'(cur_kernel[6]), 8'(cur_kernel[5]),
                        8'(cur_kernel[4])});
    tx_words.push_back({rnd[31:8], 8'(cur_kernel[8])});  // upper lanes are don't care
    tx_words.push_back(32'(cur_bias));
    @(posedge clk);
    command <= CMD_LOAD_COEF;
    push_stream("a coefficient beat to be accepted");
    wait_flag("coef_done", F_COEF, 1'b1);
    check($sformatf("%s s_ready after coef load", row_name[t]), 32'd0, 32'(s_ready));
  endtask

  // zero padded 3x3 sum, bias scaled up, then relu and clip to 127
  function automatic int expect_pixel(input int w, input int r, input int c);
    int sum;
    int rr;
    int cc;
    sum = cur_bias * (1 << `CONV_FRAC_BITS);
    for (int kr = 0; kr < 3; kr++) begin
      for (int kc = 0; kc < 3; kc++) begin
        rr = r + kr - 1;
        cc = c + kc - 1;
        if (rr >= 0 && rr < w && cc >= 0 && cc < w) begin
          sum += feat[rr * w + cc] * cur_kernel[kr * 3 + kc];
        end
      end
    end
    if (sum < 0) begin
      return 0;
    end
    sum = sum / (1 << `CONV_FRAC_BITS);
    return (sum > 127) ? 127 : sum;
  endfunction

  task automatic run_and_check(input int t);
    int          w;
    int          n_words;
    int          got;
    int          cnt;
    int          px;
    logic [31:0] exp_word;
    logic [31:0] rnd;
    w = row_width[t];
    n_words = w * w / 4;
    got = 0;
    cnt = 0;
    @(posedge clk);
    command <= CMD_RUN;
    while (got < n_words) begin
      @(posedge clk);
      rnd = lcg_next();
      m_ready <= row_rand[t] ? (rnd[31:30] != 2'b00) : 1'b1;
      @(negedge clk);
      if (m_valid && m_ready) begin
        for (int j = 0; j < 4; j++) begin
          px = expect_pixel(w, (4 * got + j) / w, (4 * got + j) % w);
          exp_word[8*j +: 8] = 8'(px);
        end
        check($sformatf("%s word %0d", row_name[t], got), exp_word, m_beat.data.bias);
        check($sformatf("%s last of word %0d", row_name[t], got),
              32'(got == n_words - 1), 32'(m_beat.last));
        if (row_const[t] >= 0) begin
          check($sformatf("%s clipped word %0d", row_name[t], got),
                {4{8'(row_const[t])}}, m_beat.data.bias);
        end
        got++;
        cnt = 0;
      end else if (cnt == WAIT_MAX) begin
        report_timeout($sformatf("output word %0d of %s", got, row_name[t]));
      end else begin
        cnt++;
      end
    end
    wait_flag("conv_done", F_CONV, 1'b1);
    check($sformatf("%s m_valid after last word", row_name[t]), 32'd0, 32'(m_valid));
  endtask

  initial begin
    rstn      <= 1'b0;
    command   <= CMD_IDLE;
    width_cfg <= '0;
    s_valid   <= 1'b0;
    s_beat    <= '0;
    m_ready   <= 1'b1;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    for (int t = 0; t < NROWS; t++) begin
      load_feature(t);
      return_to_idle();
      if (row_load[t]) begin
        load_coef(t);
        return_to_idle();
      end
      run_and_check(t);
      return_to_idle();
    end
    repeat (4) @(posedge clk);
    if (uut.u_assert.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "bound assertions failed during the run");
    end
  end

endmodule

`default_nettype wire
